//--- hdl/conv_pkg.sv
`default_nettype none

package conv_pkg;

  // Array geometry
  localparam int COLS = 4;
  localparam int ROWS = 4;

  // Signed data widths
  localparam int X_BITS = 8;
  localparam int K_BITS = 8;
  localparam int M_BITS = X_BITS + K_BITS;
  localparam int Y_BITS = 24;

  // Beat accepted to product registered
  localparam int DELAY_MUL = 3;

  // Kernel support, odd widths up to KW_MAX
  localparam int KW_MAX = 3;
  localparam int KW2_BITS = 1;

  // Shift phase counter, holds up to 2*kw2
  localparam int SHIFT_BITS = KW2_BITS + 1;

  // Beats per channel group
  localparam int CIN_BITS = 8;

  // Column index on the output side
  localparam int COL_BITS = $clog2(COLS);
  localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(COLS - 1);

  // Flags carried alongside every beat
  typedef struct packed {
    logic [KW2_BITS-1:0] kw2;
    logic                is_cin_last;
    logic                is_w_first;
  } beat_tag_t;

endpackage

`default_nettype wire

//--- hdl/delay_line.sv
`default_nettype none

module delay_line #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  logic     clk,
  input  logic     resetn,
  input  logic     en,
  input  payload_t d,
  output payload_t q
);

  payload_t stage [depth];

  // Whole chain moves together, nothing moves while en is low
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < depth; i++) begin
        stage[i] <= '0;
      end
    end else if (en) begin
      stage[0] <= d;
      for (int i = 1; i < depth; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign q = stage[depth-1];

endmodule

`default_nettype wire

//--- hdl/beat_sequencer.sv
`default_nettype none

module beat_sequencer (
  input  logic                                              clk,
  input  logic                                              resetn,
  input  logic                                              s_valid,
  output logic                                              s_ready,
  input  logic                                              s_last,
  input  logic [conv_pkg::ROWS-1:0][conv_pkg::X_BITS-1:0]   s_pixels,
  input  logic [conv_pkg::COLS-1:0][conv_pkg::K_BITS-1:0]   s_weights,
  input  logic [conv_pkg::KW2_BITS-1:0]                     cfg_kw2,
  input  logic [conv_pkg::CIN_BITS-1:0]                     cfg_cin_beats,
  output logic                                              seq_valid,
  output logic                                              seq_last,
  output logic [conv_pkg::ROWS-1:0][conv_pkg::X_BITS-1:0]   seq_pixels,
  output logic [conv_pkg::COLS-1:0][conv_pkg::K_BITS-1:0]   seq_weights,
  output conv_pkg::beat_tag_t                               seq_tag,
  input  logic                                              eng_ready
);

  logic [conv_pkg::CIN_BITS-1:0] beat_cnt;
  logic [conv_pkg::CIN_BITS-1:0] cin_held;
  logic [conv_pkg::CIN_BITS-1:0] cin_now;
  logic [conv_pkg::KW2_BITS-1:0] kw2_held;
  logic [conv_pkg::KW2_BITS-1:0] kw2_now;
  logic                          first_beat;
  logic                          last_beat;
  logic                          take;

  // Slice can take a beat when empty or draining this cycle
  assign s_ready = !seq_valid || eng_ready;
  assign take    = s_valid && s_ready;

  assign first_beat = (beat_cnt == '0);

  // Config levels are live on the first beat, held for the rest of the group
  assign cin_now = first_beat ? cfg_cin_beats : cin_held;
  assign kw2_now = first_beat ? cfg_kw2 : kw2_held;

  // A zero count behaves like a count of one
  assign last_beat = ({1'b0, beat_cnt} + 1'b1) >= {1'b0, cin_now};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      seq_valid <= 1'b0;
      beat_cnt  <= '0;
      cin_held  <= '0;
      kw2_held  <= '0;
    end else begin
      if (s_ready) begin
        seq_valid <= s_valid;
      end
      if (take) begin
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
        if (first_beat) begin
          cin_held <= cfg_cin_beats;
          kw2_held <= cfg_kw2;
        end
      end
    end
  end

  // Beat payload and its tag
  always_ff @(posedge clk) begin
    if (take) begin
      seq_last            <= s_last;
      seq_pixels          <= s_pixels;
      seq_weights         <= s_weights;
      seq_tag.kw2         <= kw2_now;
      seq_tag.is_cin_last <= last_beat;
      seq_tag.is_w_first  <= first_beat;
    end
  end

endmodule

`default_nettype wire

//--- hdl/proc_engine.sv
`default_nettype none

module proc_engine (
  input  logic                                                          clk,
  input  logic                                                          resetn,
  input  logic                                                          seq_valid,
  input  logic                                                          seq_last,
  input  logic [conv_pkg::ROWS-1:0][conv_pkg::X_BITS-1:0]               seq_pixels,
  input  logic [conv_pkg::COLS-1:0][conv_pkg::K_BITS-1:0]               seq_weights,
  input  conv_pkg::beat_tag_t                                           seq_tag,
  output logic                                                          eng_ready,
  output logic                                                          res_valid,
  output logic                                                          res_last,
  output logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][conv_pkg::Y_BITS-1:0] res_data,
  input  logic                                                          res_ready
);

  typedef struct packed {
    logic                valid;
    logic                last;
    conv_pkg::beat_tag_t tag;
  } ctrl_t;

  ctrl_t ctrl_in;
  ctrl_t ctrl_q [conv_pkg::COLS];

  logic en;
  logic mul_en;
  logic load_en;
  logic hold;
  logic rel_pulse;
  logic sel_shift;
  logic grp_last;
  logic cin_done;

  logic [conv_pkg::SHIFT_BITS-1:0] shift_step;
  logic [conv_pkg::SHIFT_BITS-1:0] shift_len;
  logic [conv_pkg::KW2_BITS-1:0]   shift_kw2;

  logic [conv_pkg::COLS-1:0] cin_flag;
  logic [conv_pkg::COLS-1:0] shift_hit;
  logic [conv_pkg::COLS-1:0] acc_en;

  // Column offset within its segment, one table per kw2
  logic [conv_pkg::SHIFT_BITS-1:0] seg_off [conv_pkg::KW_MAX/2+1][conv_pkg::COLS];

  logic [conv_pkg::ROWS-1:0][conv_pkg::COLS-1:0][conv_pkg::X_BITS-1:0] pix;
  logic [conv_pkg::COLS-1:0][conv_pkg::K_BITS-1:0]                     wgt;

  // Frozen while a result waits, plus one release cycle after it leaves
  assign en        = !hold || rel_pulse;
  assign sel_shift = (shift_step != '0);
  assign mul_en    = en && !sel_shift;
  assign eng_ready = mul_en;
  assign load_en   = mul_en && seq_valid;
  assign shift_len = {shift_kw2, 1'b0};
  assign cin_done  = &cin_flag;
  assign res_last  = grp_last;

  assign ctrl_in = '{valid: seq_valid, last: seq_last, tag: seq_tag};

  // Pixels enter at the top column and move down one column per beat
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pix <= '0;
    end else if (load_en) begin
      for (int r = 0; r < conv_pkg::ROWS; r++) begin
        pix[r] <= {seq_pixels[r], pix[r][conv_pkg::COLS-1:1]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      wgt <= seq_weights;
    end
  end

  for (genvar k = 0; k <= conv_pkg::KW_MAX / 2; k++) begin : g_lut
    for (genvar c = 0; c < conv_pkg::COLS; c++) begin : g_off
      localparam int OFF = c % (2 * k + 1);
      assign seg_off[k][c] = OFF[conv_pkg::SHIFT_BITS-1:0];
    end
  end

  for (genvar c = 0; c < conv_pkg::COLS; c++) begin : g_col
    delay_line #(
      .payload_t (ctrl_t),
      .depth     (conv_pkg::DELAY_MUL)
    ) ctrl_dl (
      .clk    (clk),
      .resetn (resetn),
      .en     (mul_en),
      .d      (ctrl_in),
      .q      (ctrl_q[c])
    );

    assign cin_flag[c] = ctrl_q[c].valid && ctrl_q[c].tag.is_cin_last;

    // Each non-start column adds its neighbour once, in step order
    assign shift_hit[c] = sel_shift && (seg_off[shift_kw2][c] == shift_step);
    assign acc_en[c]    = en && (sel_shift ? shift_hit[c] : ctrl_q[c].valid);

    for (genvar r = 0; r < conv_pkg::ROWS; r++) begin : g_row
      logic signed [conv_pkg::M_BITS-1:0] mul_comb;
      logic signed [conv_pkg::M_BITS-1:0] prod;
      logic        [conv_pkg::Y_BITS-1:0] left_sum;
      logic        [conv_pkg::Y_BITS-1:0] add_a;
      logic        [conv_pkg::Y_BITS-1:0] add_b;

      assign mul_comb = $signed(pix[r][c]) * $signed(wgt[c]);

      delay_line #(
        .payload_t (logic signed [conv_pkg::M_BITS-1:0]),
        .depth     (conv_pkg::DELAY_MUL - 1)
      ) prod_dl (
        .clk    (clk),
        .resetn (resetn),
        .en     (mul_en),
        .d      (mul_comb),
        .q      (prod)
      );

      if (c == 0) begin : g_edge
        assign left_sum = '0;
      end else begin : g_inner
        assign left_sum = res_data[c-1][r];
      end

      assign add_a = sel_shift ? left_sum :
                     {{(conv_pkg::Y_BITS - conv_pkg::M_BITS){prod[conv_pkg::M_BITS-1]}}, prod};
      // First beat of a group starts the sum over
      assign add_b = (!sel_shift && ctrl_q[c].tag.is_w_first) ? '0 : res_data[c][r];

      always_ff @(posedge clk) begin
        if (acc_en[c]) begin
          res_data[c][r] <= add_a + add_b;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      res_valid  <= 1'b0;
      hold       <= 1'b0;
      rel_pulse  <= 1'b0;
      shift_step <= '0;
      shift_kw2  <= '0;
      grp_last   <= 1'b0;
    end else begin
      rel_pulse <= res_valid && res_ready;
      if (res_valid && res_ready) begin
        res_valid <= 1'b0;
      end
      if (en) begin
        if (sel_shift) begin
          if (shift_step == shift_len) begin
            shift_step <= '0;
            hold       <= 1'b1;
            res_valid  <= 1'b1;
          end else begin
            shift_step <= shift_step + 1'b1;
          end
        end else begin
          hold <= cin_done && (ctrl_q[0].tag.kw2 == '0);
          if (cin_done) begin
            if (ctrl_q[0].tag.kw2 == '0) begin
              res_valid <= 1'b1;
            end else begin
              // Pipe is already past this beat, keep its kw2 for the shift
              shift_step <= {{(conv_pkg::SHIFT_BITS-1){1'b0}}, 1'b1};
              shift_kw2  <= ctrl_q[0].tag.kw2;
            end
          end
          if (ctrl_q[0].valid) begin
            grp_last <= (ctrl_q[0].tag.is_w_first ? 1'b0 : grp_last) | ctrl_q[0].last;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/column_serializer.sv
`default_nettype none

module column_serializer (
  input  logic                                                          clk,
  input  logic                                                          resetn,
  input  logic                                                          res_valid,
  input  logic                                                          res_last,
  input  logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][conv_pkg::Y_BITS-1:0] res_data,
  output logic                                                          res_ready,
  output logic                                                          m_valid,
  output logic                                                          m_last,
  output logic [conv_pkg::ROWS-1:0][conv_pkg::Y_BITS-1:0]               m_data,
  output logic [conv_pkg::COL_BITS-1:0]                                 m_col,
  input  logic                                                          m_ready
);

  logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][conv_pkg::Y_BITS-1:0] data_r;
  logic                                                              last_r;
  logic [conv_pkg::COL_BITS-1:0]                                     col;
  logic                                                              busy;
  logic                                                              last_col;
  logic                                                              load;

  // New result only when the previous one is fully out
  assign res_ready = !busy;
  assign load      = res_valid && !busy;
  assign last_col  = (col == conv_pkg::LAST_COL);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy <= 1'b0;
      col  <= '0;
    end else if (load) begin
      busy <= 1'b1;
      col  <= '0;
    end else if (busy && m_ready) begin
      if (last_col) begin
        busy <= 1'b0;
      end
      col <= col + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data_r <= res_data;
      last_r <= res_last;
    end
  end

  assign m_valid = busy;
  assign m_col   = col;
  assign m_data  = data_r[col];
  // Frame end only on the final column
  assign m_last  = last_r && last_col;

endmodule

`default_nettype wire

//--- hdl/conv_top.sv
`default_nettype none

module conv_top (
  input  logic                                             clk,
  input  logic                                             resetn,
  input  logic                                             s_valid,
  output logic                                             s_ready,
  input  logic                                             s_last,
  input  logic [conv_pkg::ROWS-1:0][conv_pkg::X_BITS-1:0]  s_pixels,
  input  logic [conv_pkg::COLS-1:0][conv_pkg::K_BITS-1:0]  s_weights,
  input  logic [conv_pkg::KW2_BITS-1:0]                    cfg_kw2,
  input  logic [conv_pkg::CIN_BITS-1:0]                    cfg_cin_beats,
  output logic                                             m_valid,
  input  logic                                             m_ready,
  output logic                                             m_last,
  output logic [conv_pkg::ROWS-1:0][conv_pkg::Y_BITS-1:0]  m_data,
  output logic [conv_pkg::COL_BITS-1:0]                    m_col
);

  // Sequencer to engine
  logic                                            seq_valid;
  logic                                            seq_last;
  logic [conv_pkg::ROWS-1:0][conv_pkg::X_BITS-1:0] seq_pixels;
  logic [conv_pkg::COLS-1:0][conv_pkg::K_BITS-1:0] seq_weights;
  conv_pkg::beat_tag_t                             seq_tag;
  logic                                            eng_ready;

  // Engine to serializer
  logic res_valid;
  logic res_last;
  logic res_ready;
  logic [conv_pkg::COLS-1:0][conv_pkg::ROWS-1:0][conv_pkg::Y_BITS-1:0] res_data;

  beat_sequencer seq_i (
    .clk           (clk),
    .resetn        (resetn),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .s_last        (s_last),
    .s_pixels      (s_pixels),
    .s_weights     (s_weights),
    .cfg_kw2       (cfg_kw2),
    .cfg_cin_beats (cfg_cin_beats),
    .seq_valid     (seq_valid),
    .seq_last      (seq_last),
    .seq_pixels    (seq_pixels),
    .seq_weights   (seq_weights),
    .seq_tag       (seq_tag),
    .eng_ready     (eng_ready)
  );

  proc_engine eng_i (
    .clk         (clk),
    .resetn      (resetn),
    .seq_valid   (seq_valid),
    .seq_last    (seq_last),
    .seq_pixels  (seq_pixels),
    .seq_weights (seq_weights),
    .seq_tag     (seq_tag),
    .eng_ready   (eng_ready),
    .res_valid   (res_valid),
    .res_last    (res_last),
    .res_data    (res_data),
    .res_ready   (res_ready)
  );

  column_serializer ser_i (
    .clk       (clk),
    .resetn    (resetn),
    .res_valid (res_valid),
    .res_last  (res_last),
    .res_data  (res_data),
    .res_ready (res_ready),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_data    (m_data),
    .m_col     (m_col),
    .m_ready   (m_ready)
  );

endmodule

`default_nettype wire

//--- test/conv_tb.sv
`default_nettype none

module conv_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [conv_pkg::KW2_BITS-1:0] kw2;
    logic [conv_pkg::CIN_BITS-1:0] cin_beats;
    logic [7:0]                    groups;
    logic [1:0]                    stall;
  } test_entry_t;

  typedef struct packed {
    logic [conv_pkg::ROWS-1:0][conv_pkg::Y_BITS-1:0] data;
    logic [conv_pkg::COL_BITS-1:0]                   col;
    logic                                            last;
  } out_beat_t;

  localparam int NUM_TESTS = 6;

  // kw2, beats per group, groups, m_ready stall level (0 never stalls)
  test_entry_t tests [NUM_TESTS] = '{
    '{1'b0, 8'd5, 8'd1, 2'd0},
    '{1'b0, 8'd3, 8'd3, 2'd0},
    '{1'b1, 8'd4, 8'd2, 2'd0},
    '{1'b1, 8'd6, 8'd3, 2'd2},
    '{1'b0, 8'd1, 8'd4, 2'd3},
    '{1'b1, 8'd2, 8'd3, 2'd1}
  };

  logic                                            clk;
  logic                                            resetn;
  logic                                            s_valid;
  logic                                            s_ready;
  logic                                            s_last;
  logic [conv_pkg::ROWS-1:0][conv_pkg::X_BITS-1:0] s_pixels;
  logic [conv_pkg::COLS-1:0][conv_pkg::K_BITS-1:0] s_weights;
  logic [conv_pkg::KW2_BITS-1:0]                   cfg_kw2;
  logic [conv_pkg::CIN_BITS-1:0]                   cfg_cin_beats;
  logic                                            m_valid;
  logic                                            m_ready;
  logic                                            m_last;
  logic [conv_pkg::ROWS-1:0][conv_pkg::Y_BITS-1:0] m_data;
  logic [conv_pkg::COL_BITS-1:0]                   m_col;

  logic [31:0] data_rng;
  logic [31:0] stall_rng;
  int          error_count;
  int          check_count;

  // Beats still to send and results still to see
  logic [conv_pkg::ROWS-1:0][conv_pkg::X_BITS-1:0] pix_q [$];
  logic [conv_pkg::COLS-1:0][conv_pkg::K_BITS-1:0] wgt_q [$];
  logic                                            last_q [$];
  out_beat_t                                       exp_q [$];

  // Pixel vectors of the latest beats, entry 0 is the newest
  logic [conv_pkg::ROWS-1:0][conv_pkg::X_BITS-1:0] hist [conv_pkg::COLS];

  conv_top dut_i (
    .clk           (clk),
    .resetn        (resetn),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .s_last        (s_last),
    .s_pixels      (s_pixels),
    .s_weights     (s_weights),
    .cfg_kw2       (cfg_kw2),
    .cfg_cin_beats (cfg_cin_beats),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .m_last        (m_last),
    .m_data        (m_data),
    .m_col         (m_col)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
    end
  endtask

  // Reference model, fills the beat queues and the expected results
  task automatic build_test(input test_entry_t t);
    int                                              sums [conv_pkg::COLS][conv_pkg::ROWS];
    int                                              seg;
    int                                              acc;
    logic [conv_pkg::ROWS-1:0][conv_pkg::X_BITS-1:0] px;
    logic [conv_pkg::COLS-1:0][conv_pkg::K_BITS-1:0] wt;
    out_beat_t                                       ob;
    seg = 2 * int'(t.kw2) + 1;
    for (int g = 0; g < int'(t.groups); g++) begin
      for (int c = 0; c < conv_pkg::COLS; c++) begin
        for (int r = 0; r < conv_pkg::ROWS; r++) begin
          sums[c][r] = 0;
        end
      end
      for (int j = 0; j < int'(t.cin_beats); j++) begin
        for (int r = 0; r < conv_pkg::ROWS; r++) begin
          data_rng = xorshift(data_rng);
          px[r] = data_rng[conv_pkg::X_BITS-1:0];
        end
        for (int c = 0; c < conv_pkg::COLS; c++) begin
          data_rng = xorshift(data_rng);
          wt[c] = data_rng[conv_pkg::K_BITS-1:0];
        end
        for (int k = conv_pkg::COLS - 1; k > 0; k--) begin
          hist[k] = hist[k-1];
        end
        hist[0] = px;
        // Column c sees the pixel from COLS-1-c beats back
        for (int c = 0; c < conv_pkg::COLS; c++) begin
          for (int r = 0; r < conv_pkg::ROWS; r++) begin
            sums[c][r] += $signed(hist[conv_pkg::COLS-1-c][r]) * $signed(wt[c]);
          end
        end
        pix_q.push_back(px);
        wgt_q.push_back(wt);
        last_q.push_back((g == int'(t.groups) - 1) && (j == int'(t.cin_beats) - 1));
      end
      // Running sum from the segment start up to each column
      for (int c = 0; c < conv_pkg::COLS; c++) begin
        for (int r = 0; r < conv_pkg::ROWS; r++) begin
          acc = 0;
          for (int k = (c / seg) * seg; k <= c; k++) begin
            acc += sums[k][r];
          end
          ob.data[r] = acc[conv_pkg::Y_BITS-1:0];
        end
        ob.col  = c[conv_pkg::COL_BITS-1:0];
        ob.last = (g == int'(t.groups) - 1) && (c == conv_pkg::COLS - 1);
        exp_q.push_back(ob);
      end
    end
  endtask

  // Starts and ends on a falling edge
  task automatic drive_beats();
    while (pix_q.size() > 0) begin
      s_valid   = 1'b1;
      s_pixels  = pix_q.pop_front();
      s_weights = wgt_q.pop_front();
      s_last    = last_q.pop_front();
      while (!s_ready) begin
        @(negedge clk);
      end
      @(negedge clk);
    end
    s_valid = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic collect_results(input logic [1:0] stall);
    out_beat_t want;
    while (exp_q.size() > 0) begin
      stall_rng = xorshift(stall_rng);
      m_ready = (stall_rng[1:0] >= stall);
      if (m_valid && m_ready) begin
        want = exp_q.pop_front();
        check_value("m_col", 32'(m_col), 32'(want.col));
        check_value("m_last", 32'(m_last), 32'(want.last));
        for (int r = 0; r < conv_pkg::ROWS; r++) begin
          check_value($sformatf("m_data[%0d]", r), 32'(m_data[r]), 32'(want.data[r]));
        end
      end
      @(negedge clk);
    end
    m_ready = 1'b0;
  endtask

  initial begin
    int errors_before;
    resetn        = 1'b0;
    s_valid       = 1'b0;
    s_last        = 1'b0;
    s_pixels      = '0;
    s_weights     = '0;
    cfg_kw2       = '0;
    cfg_cin_beats = '0;
    m_ready       = 1'b0;
    error_count   = 0;
    check_count   = 0;
    data_rng      = 32'd85281;
    stall_rng     = xorshift(32'd85281);
    for (int k = 0; k < conv_pkg::COLS; k++) begin
      hist[k] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    @(negedge clk);
    check_value("m_valid", 32'(m_valid), 32'd0);
    check_value("s_ready", 32'(s_ready), 32'd1);

    for (int i = 0; i < NUM_TESTS; i++) begin
      errors_before = error_count;
      build_test(tests[i]);
      cfg_kw2       = tests[i].kw2;
      cfg_cin_beats = tests[i].cin_beats;
      fork
        drive_beats();
        collect_results(tests[i].stall);
      join
      $display("test %0d: kw2 %0d, %0d groups of %0d beats, stall %0d, %0d errors",
               i, tests[i].kw2, tests[i].groups, tests[i].cin_beats, tests[i].stall,
               error_count - errors_before);
    end

    // Nothing left over once every result is out
    repeat (40) @(negedge clk);
    check_value("m_valid", 32'(m_valid), 32'd0);
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    int total_beats;
    int limit;
    total_beats = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      total_beats += int'(tests[i].cin_beats) * int'(tests[i].groups);
    end
    limit = total_beats * 40 + 500;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the results stopped arriving", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hdl/conv_pkg.sv
hdl/delay_line.sv
hdl/beat_sequencer.sv
hdl/proc_engine.sv
hdl/column_serializer.sv
hdl/conv_top.sv
test/conv_tb.sv

//--- Makefile
TOP = conv_tb
SRCS = $(shell cat files.f)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP) -o V$(TOP)

# Pass only when the testbench prints its pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall -f files.f --top-module conv_top

clean:
	rm -rf obj_dir
